//--- design/pcie_tx_pkg.sv
`default_nettype none

package pcie_tx_pkg;

   // ------------------------------
   // Transmit sources
   // ------------------------------

   // Host requests and completions
   localparam int NUM_CH = 2;

   // Channel tag carried with every beat
   // 0 = host request, 1 = completion
   typedef logic t_ch_id;

   // ------------------------------
   // Mux arbitration
   // ------------------------------

   // Idle waits for a valid source, busy holds the grant until tlast
   typedef enum logic {
      ARB_IDLE = 1'b0,
      ARB_BUSY = 1'b1
   } t_arb_state;

   // ------------------------------
   // Application error reporting
   // ------------------------------

   // Reason codes for malformed byte-enables
   typedef enum logic [1:0] {
      ERR_NONE      = 2'd0,
      ERR_KEEP_ZERO = 2'd1,   // no byte enabled
      ERR_KEEP_GAP  = 2'd2    // enabled bytes not packed from byte 0
   } t_err_info;

endpackage

`default_nettype wire

//--- design/pcie_tx_stream_if.sv
`timescale 1ns/10ps
`default_nettype none

interface pcie_tx_stream_if #(
   parameter int DATA_W = 64
);

   localparam int KEEP_W = DATA_W / 8;

   // Handshake
   logic                 tvalid;
   logic                 tready;

   // Beat payload
   logic [DATA_W-1:0]    tdata;
   logic [KEEP_W-1:0]    tkeep;
   logic                 tlast;
   pcie_tx_pkg::t_ch_id  tchan;

   // Driving side of the stream
   modport source (
      output tvalid,
      output tdata,
      output tkeep,
      output tlast,
      output tchan,
      input  tready
   );

   // Receiving side of the stream
   modport sink (
      input  tvalid,
      input  tdata,
      input  tkeep,
      input  tlast,
      input  tchan,
      output tready
   );

endinterface

`default_nettype wire

//--- design/pcie_tx_arb_mux.sv
`timescale 1ns/10ps
`default_nettype none

module pcie_tx_arb_mux #(
   parameter int DATA_W = 64
) (
   input  logic                  avl_clk,
   input  logic                  i_rst_n,

   // Host request source
   input  logic                  i_req_tvalid,
   input  logic [DATA_W-1:0]     i_req_tdata,
   input  logic [DATA_W/8-1:0]   i_req_tkeep,
   input  logic                  i_req_tlast,
   output logic                  o_req_tready,

   // Completion source
   input  logic                  i_cpl_tvalid,
   input  logic [DATA_W-1:0]     i_cpl_tdata,
   input  logic [DATA_W/8-1:0]   i_cpl_tkeep,
   input  logic                  i_cpl_tlast,
   output logic                  o_cpl_tready,

   pcie_tx_stream_if.source      o_stream
);

   localparam int KEEP_W = DATA_W / 8;

   // Sources gathered into arrays indexed by channel id
   logic                      in_valid [pcie_tx_pkg::NUM_CH];
   logic [DATA_W-1:0]         in_data  [pcie_tx_pkg::NUM_CH];
   logic [KEEP_W-1:0]         in_keep  [pcie_tx_pkg::NUM_CH];
   logic                      in_last  [pcie_tx_pkg::NUM_CH];

   pcie_tx_pkg::t_arb_state   state;
   pcie_tx_pkg::t_ch_id       grant_ch;
   pcie_tx_pkg::t_ch_id       last_ch;
   pcie_tx_pkg::t_ch_id       sel_ch;
   pcie_tx_pkg::t_ch_id       cur_ch;
   logic                      fire;

   always_comb begin
      in_valid[0] = i_req_tvalid;
      in_data[0]  = i_req_tdata;
      in_keep[0]  = i_req_tkeep;
      in_last[0]  = i_req_tlast;
      in_valid[1] = i_cpl_tvalid;
      in_data[1]  = i_cpl_tdata;
      in_keep[1]  = i_cpl_tkeep;
      in_last[1]  = i_cpl_tlast;
   end

   // Round-robin pick, the channel not served last wins a tie
   always_comb begin
      if (in_valid[0] && in_valid[1]) begin
         sel_ch = ~last_ch;
      end else if (in_valid[1]) begin
         sel_ch = 1'b1;
      end else begin
         sel_ch = 1'b0;
      end
      cur_ch = (state == pcie_tx_pkg::ARB_BUSY) ? grant_ch : sel_ch;
   end

   // ------------------------------
   // Beat path, no register stage
   // ------------------------------
   assign o_stream.tvalid = in_valid[cur_ch];
   assign o_stream.tdata  = in_data[cur_ch];
   assign o_stream.tkeep  = in_keep[cur_ch];
   assign o_stream.tlast  = in_last[cur_ch];
   assign o_stream.tchan  = cur_ch;

   assign fire = o_stream.tvalid & o_stream.tready;

   // Only the channel being served sees the FIFO ready
   assign o_req_tready = (cur_ch == 1'b0) & o_stream.tready;
   assign o_cpl_tready = (cur_ch == 1'b1) & o_stream.tready;

   // ------------------------------
   // Grant FSM
   // ------------------------------
   always_ff @(posedge avl_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state    <= pcie_tx_pkg::ARB_IDLE;
         grant_ch <= 1'b0;
         last_ch  <= 1'b1;
      end else begin
         case (state)
            pcie_tx_pkg::ARB_IDLE: begin
               if (o_stream.tvalid) begin
                  if (fire && o_stream.tlast) begin
                     // Single-beat packet, grant never needs holding
                     last_ch <= sel_ch;
                  end else begin
                     // Lock the pick so a stalled beat stays stable
                     state    <= pcie_tx_pkg::ARB_BUSY;
                     grant_ch <= sel_ch;
                  end
               end
            end
            pcie_tx_pkg::ARB_BUSY: begin
               if (fire && o_stream.tlast) begin
                  state   <= pcie_tx_pkg::ARB_IDLE;
                  last_ch <= grant_ch;
               end
            end
            default: begin
               state <= pcie_tx_pkg::ARB_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/pcie_tx_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module pcie_tx_fifo #(
   parameter int DATA_W     = 64,
   parameter int FIFO_DEPTH = 8
) (
   input  logic               avl_clk,
   input  logic               i_rst_n,

   pcie_tx_stream_if.sink     i_stream,
   pcie_tx_stream_if.source   o_stream
);

   localparam int KEEP_W  = DATA_W / 8;
   localparam int PTR_W   = $clog2(FIFO_DEPTH);
   localparam int CNT_W   = PTR_W + 1;
   // Channel, last, keep and data packed into one entry
   localparam int ENTRY_W = 1 + 1 + KEEP_W + DATA_W;

   logic [ENTRY_W-1:0]  mem [FIFO_DEPTH];
   logic [PTR_W-1:0]    wr_ptr;
   logic [PTR_W-1:0]    rd_ptr;
   logic [CNT_W-1:0]    count;
   logic [ENTRY_W-1:0]  wr_entry;
   logic [ENTRY_W-1:0]  rd_entry;
   logic                wr_en;
   logic                rd_en;

   assign i_stream.tready = (count != CNT_W'(FIFO_DEPTH));
   assign o_stream.tvalid = (count != '0);

   assign wr_en = i_stream.tvalid & i_stream.tready;
   assign rd_en = o_stream.tvalid & o_stream.tready;

   assign wr_entry = {i_stream.tchan, i_stream.tlast, i_stream.tkeep, i_stream.tdata};
   assign rd_entry = mem[rd_ptr];

   // Unpack the head entry
   assign o_stream.tdata = rd_entry[DATA_W-1:0];
   assign o_stream.tkeep = rd_entry[DATA_W +: KEEP_W];
   assign o_stream.tlast = rd_entry[DATA_W+KEEP_W];
   assign o_stream.tchan = rd_entry[ENTRY_W-1];

   // ------------------------------
   // Storage
   // ------------------------------
   always_ff @(posedge avl_clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= wr_entry;
      end
   end

   // ------------------------------
   // Pointers and occupancy
   // ------------------------------
   always_ff @(posedge avl_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // Pointers wrap on their own, depth is a power of two
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/pcie_tx_avst_adapter.sv
`timescale 1ns/10ps
`default_nettype none

module pcie_tx_avst_adapter #(
   parameter int DATA_W = 64
) (
   input  logic                                avl_clk,
   input  logic                                i_rst_n,

   pcie_tx_stream_if.sink                      i_stream,

   // Avalon-ST transmit side
   output logic                                o_avl_tx_valid,
   output logic [DATA_W-1:0]                   o_avl_tx_data,
   output logic                                o_avl_tx_sop,
   output logic                                o_avl_tx_eop,
   output logic [$clog2(DATA_W/8+1)-1:0]       o_avl_tx_empty,
   output pcie_tx_pkg::t_ch_id                 o_avl_tx_chan,
   input  logic                                i_avl_tx_ready,

   // Application error strobe
   output logic                                o_err_valid,
   output pcie_tx_pkg::t_ch_id                 o_err_chan,
   output pcie_tx_pkg::t_err_info              o_err_info
);

   localparam int KEEP_W  = DATA_W / 8;
   localparam int EMPTY_W = $clog2(KEEP_W + 1);

   logic                      load;
   logic                      in_pkt;
   logic [EMPTY_W-1:0]        empty_cnt;
   logic [KEEP_W-1:0]         keep_inc;
   logic                      keep_gap;
   pcie_tx_pkg::t_err_info    err_code;

   // Output register takes a new beat when empty or being drained
   assign i_stream.tready = ~o_avl_tx_valid | i_avl_tx_ready;
   assign load            = i_stream.tvalid & i_stream.tready;

   // ------------------------------
   // Keep decode
   // ------------------------------

   // Empty is the number of cleared byte-enables
   always_comb begin
      empty_cnt = '0;
      for (int i = 0; i < KEEP_W; i++) begin
         if (!i_stream.tkeep[i]) begin
            empty_cnt = empty_cnt + 1'b1;
         end
      end
   end

   // A packed keep plus one leaves no bit shared with the keep
   assign keep_inc = i_stream.tkeep + {{(KEEP_W-1){1'b0}}, 1'b1};
   assign keep_gap = |(i_stream.tkeep & keep_inc);

   always_comb begin
      if (i_stream.tkeep == '0) begin
         err_code = pcie_tx_pkg::ERR_KEEP_ZERO;
      end else if (keep_gap) begin
         err_code = pcie_tx_pkg::ERR_KEEP_GAP;
      end else begin
         err_code = pcie_tx_pkg::ERR_NONE;
      end
   end

   // ------------------------------
   // Control state
   // ------------------------------
   always_ff @(posedge avl_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_avl_tx_valid <= 1'b0;
         o_err_valid    <= 1'b0;
         in_pkt         <= 1'b0;
      end else begin
         // Pulse once per bad beat, even while the beat is stalled
         o_err_valid <= load && (err_code != pcie_tx_pkg::ERR_NONE);
         if (load) begin
            o_avl_tx_valid <= 1'b1;
            in_pkt         <= ~i_stream.tlast;
         end else if (i_avl_tx_ready) begin
            o_avl_tx_valid <= 1'b0;
         end
      end
   end

   // Payload and error detail
   always_ff @(posedge avl_clk) begin
      if (load) begin
         o_avl_tx_data  <= i_stream.tdata;
         o_avl_tx_sop   <= ~in_pkt;
         o_avl_tx_eop   <= i_stream.tlast;
         o_avl_tx_empty <= empty_cnt;
         o_avl_tx_chan  <= i_stream.tchan;
         o_err_chan     <= i_stream.tchan;
         o_err_info     <= err_code;
      end
   end

endmodule

`default_nettype wire

//--- design/pcie_tx_top.sv
`timescale 1ns/10ps
`default_nettype none

module pcie_tx_top #(
   parameter int DATA_W     = 64,
   parameter int FIFO_DEPTH = 8
) (
   input  logic                                avl_clk,
   input  logic                                i_rst_n,

   // Channel 0, host requests
   input  logic                                i_req_tvalid,
   input  logic [DATA_W-1:0]                   i_req_tdata,
   input  logic [DATA_W/8-1:0]                 i_req_tkeep,
   input  logic                                i_req_tlast,
   output logic                                o_req_tready,

   // Channel 1, completions
   input  logic                                i_cpl_tvalid,
   input  logic [DATA_W-1:0]                   i_cpl_tdata,
   input  logic [DATA_W/8-1:0]                 i_cpl_tkeep,
   input  logic                                i_cpl_tlast,
   output logic                                o_cpl_tready,

   // Avalon-ST transmit output
   output logic                                o_avl_tx_valid,
   output logic [DATA_W-1:0]                   o_avl_tx_data,
   output logic                                o_avl_tx_sop,
   output logic                                o_avl_tx_eop,
   output logic [$clog2(DATA_W/8+1)-1:0]       o_avl_tx_empty,
   output pcie_tx_pkg::t_ch_id                 o_avl_tx_chan,
   input  logic                                i_avl_tx_ready,

   // Error reporting
   output logic                                o_err_valid,
   output pcie_tx_pkg::t_ch_id                 o_err_chan,
   output pcie_tx_pkg::t_err_info              o_err_info
);

   pcie_tx_stream_if #(.DATA_W(DATA_W)) mux_to_fifo ();
   pcie_tx_stream_if #(.DATA_W(DATA_W)) fifo_to_adapter ();

   // ------------------------------
   // Producer, merges both sources
   // ------------------------------
   pcie_tx_arb_mux #(
      .DATA_W (DATA_W)
   ) u_arb_mux (
      .avl_clk      (avl_clk),
      .i_rst_n      (i_rst_n),
      .i_req_tvalid (i_req_tvalid),
      .i_req_tdata  (i_req_tdata),
      .i_req_tkeep  (i_req_tkeep),
      .i_req_tlast  (i_req_tlast),
      .o_req_tready (o_req_tready),
      .i_cpl_tvalid (i_cpl_tvalid),
      .i_cpl_tdata  (i_cpl_tdata),
      .i_cpl_tkeep  (i_cpl_tkeep),
      .i_cpl_tlast  (i_cpl_tlast),
      .o_cpl_tready (o_cpl_tready),
      .o_stream     (mux_to_fifo)
   );

   // Beat buffer
   pcie_tx_fifo #(
      .DATA_W     (DATA_W),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_fifo (
      .avl_clk  (avl_clk),
      .i_rst_n  (i_rst_n),
      .i_stream (mux_to_fifo),
      .o_stream (fifo_to_adapter)
   );

   // ------------------------------
   // Consumer, AXI-stream to Avalon-ST
   // ------------------------------
   pcie_tx_avst_adapter #(
      .DATA_W (DATA_W)
   ) u_avst_adapter (
      .avl_clk        (avl_clk),
      .i_rst_n        (i_rst_n),
      .i_stream       (fifo_to_adapter),
      .o_avl_tx_valid (o_avl_tx_valid),
      .o_avl_tx_data  (o_avl_tx_data),
      .o_avl_tx_sop   (o_avl_tx_sop),
      .o_avl_tx_eop   (o_avl_tx_eop),
      .o_avl_tx_empty (o_avl_tx_empty),
      .o_avl_tx_chan  (o_avl_tx_chan),
      .i_avl_tx_ready (i_avl_tx_ready),
      .o_err_valid    (o_err_valid),
      .o_err_chan     (o_err_chan),
      .o_err_info     (o_err_info)
   );

endmodule

`default_nettype wire

//--- verification/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS = 100
) (
   output logic avl_clk
);

   // Free-running clock, low for the first half period
   initial begin
      avl_clk = 1'b0;
   end

   always #(PERIOD_NS / 2) avl_clk = ~avl_clk;

endmodule

`default_nettype wire

//--- verification/tb_pcie_tx_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_pcie_tx_top;

   localparam int DATA_W  = 64;
   localparam int KEEP_W  = DATA_W / 8;
   localparam int EMPTY_W = $clog2(KEEP_W + 1);
   // FIFO entries of the DUT at its default parameters
   localparam int FIFO_DEPTH = 8;

   // Beats sent by the five tests in order
   localparam int TOTAL_BEATS = 3 + 10 + 16 + 12 + 2;
   localparam int CYCLE_LIMIT = 20 * TOTAL_BEATS + 200;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [KEEP_W-1:0] keep;
      logic              last;
   } in_beat_t;

   typedef struct packed {
      logic [DATA_W-1:0]   data;
      logic                sop;
      logic                eop;
      logic [EMPTY_W-1:0]  empty;
      pcie_tx_pkg::t_ch_id chan;
   } out_beat_t;

   typedef struct packed {
      pcie_tx_pkg::t_ch_id    chan;
      pcie_tx_pkg::t_err_info info;
   } err_t;

   logic                   avl_clk;
   logic                   i_rst_n;
   logic                   i_req_tvalid;
   logic [DATA_W-1:0]      i_req_tdata;
   logic [KEEP_W-1:0]      i_req_tkeep;
   logic                   i_req_tlast;
   logic                   o_req_tready;
   logic                   i_cpl_tvalid;
   logic [DATA_W-1:0]      i_cpl_tdata;
   logic [KEEP_W-1:0]      i_cpl_tkeep;
   logic                   i_cpl_tlast;
   logic                   o_cpl_tready;
   logic                   o_avl_tx_valid;
   logic [DATA_W-1:0]      o_avl_tx_data;
   logic                   o_avl_tx_sop;
   logic                   o_avl_tx_eop;
   logic [EMPTY_W-1:0]     o_avl_tx_empty;
   pcie_tx_pkg::t_ch_id    o_avl_tx_chan;
   logic                   i_avl_tx_ready;
   logic                   o_err_valid;
   pcie_tx_pkg::t_ch_id    o_err_chan;
   pcie_tx_pkg::t_err_info o_err_info;

   // Beats waiting to be driven per channel and the beats the output must show
   in_beat_t  stage_q [pcie_tx_pkg::NUM_CH][$];
   out_beat_t exp_q[$];
   err_t      err_q[$];

   int err_count   = 0;
   int n_checks    = 0;
   int n_tests     = 0;
   int cycle_count = 0;

   tb_clk_gen #(
      .PERIOD_NS (100)
   ) u_clk_gen (
      .avl_clk (avl_clk)
   );

   pcie_tx_top u_pcie_tx_top (
      .avl_clk        (avl_clk),
      .i_rst_n        (i_rst_n),
      .i_req_tvalid   (i_req_tvalid),
      .i_req_tdata    (i_req_tdata),
      .i_req_tkeep    (i_req_tkeep),
      .i_req_tlast    (i_req_tlast),
      .o_req_tready   (o_req_tready),
      .i_cpl_tvalid   (i_cpl_tvalid),
      .i_cpl_tdata    (i_cpl_tdata),
      .i_cpl_tkeep    (i_cpl_tkeep),
      .i_cpl_tlast    (i_cpl_tlast),
      .o_cpl_tready   (o_cpl_tready),
      .o_avl_tx_valid (o_avl_tx_valid),
      .o_avl_tx_data  (o_avl_tx_data),
      .o_avl_tx_sop   (o_avl_tx_sop),
      .o_avl_tx_eop   (o_avl_tx_eop),
      .o_avl_tx_empty (o_avl_tx_empty),
      .o_avl_tx_chan  (o_avl_tx_chan),
      .i_avl_tx_ready (i_avl_tx_ready),
      .o_err_valid    (o_err_valid),
      .o_err_chan     (o_err_chan),
      .o_err_info     (o_err_info)
   );

   // ------------------------------
   // Reporting and compare tasks
   // ------------------------------
   task automatic note_error(input string msg);
      err_count++;
      $display("error: %s", msg);
   endtask

   task automatic expect_true(input logic cond, input string msg);
      n_checks++;
      if (cond !== 1'b1) begin
         note_error(msg);
      end
   endtask

   task automatic report_mismatch(input string name, input logic [DATA_W-1:0] exp,
                                  input logic [DATA_W-1:0] act);
      err_count++;
      $display("mismatch %s: expected 0x%0h, got 0x%0h", name, exp, act);
   endtask

   task automatic compare_beat(input out_beat_t exp, input logic [DATA_W-1:0] data,
                               input logic sop, input logic eop,
                               input logic [EMPTY_W-1:0] empty,
                               input pcie_tx_pkg::t_ch_id chan);
      n_checks++;
      if (data !== exp.data) report_mismatch("o_avl_tx_data", exp.data, data);
      if (sop !== exp.sop) report_mismatch("o_avl_tx_sop", DATA_W'(exp.sop), DATA_W'(sop));
      if (eop !== exp.eop) report_mismatch("o_avl_tx_eop", DATA_W'(exp.eop), DATA_W'(eop));
      if (empty !== exp.empty) begin
         report_mismatch("o_avl_tx_empty", DATA_W'(exp.empty), DATA_W'(empty));
      end
      if (chan !== exp.chan) begin
         report_mismatch("o_avl_tx_chan", DATA_W'(exp.chan), DATA_W'(chan));
      end
   endtask

   task automatic compare_err(input pcie_tx_pkg::t_ch_id exp_chan,
                              input pcie_tx_pkg::t_ch_id act_chan,
                              input pcie_tx_pkg::t_err_info exp_info,
                              input pcie_tx_pkg::t_err_info act_info);
      n_checks++;
      if (act_chan !== exp_chan) begin
         report_mismatch("o_err_chan", DATA_W'(exp_chan), DATA_W'(act_chan));
      end
      if (act_info !== exp_info) begin
         report_mismatch("o_err_info", DATA_W'(exp_info), DATA_W'(act_info));
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      n_tests++;
      if (err_count == errs_before) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, err_count - errs_before);
      end
   endtask

   // ------------------------------
   // Stimulus
   // ------------------------------
   task automatic apply_reset();
      @(negedge avl_clk);
      i_rst_n        = 1'b0;
      i_avl_tx_ready = 1'b1;
      repeat (8) @(negedge avl_clk);
      i_rst_n = 1'b1;
   endtask

   task automatic set_channel(input pcie_tx_pkg::t_ch_id ch, input logic valid,
                              input in_beat_t beat);
      if (ch == 1'b0) begin
         i_req_tvalid = valid;
         i_req_tdata  = beat.data;
         i_req_tkeep  = beat.keep;
         i_req_tlast  = beat.last;
      end else begin
         i_cpl_tvalid = valid;
         i_cpl_tdata  = beat.data;
         i_cpl_tkeep  = beat.keep;
         i_cpl_tlast  = beat.last;
      end
   endtask

   // Holds the beat until the channel's ready is seen at a rising edge
   task automatic send_beat(input pcie_tx_pkg::t_ch_id ch, input in_beat_t beat);
      logic accepted;
      @(negedge avl_clk);
      set_channel(ch, 1'b1, beat);
      do begin
         @(posedge avl_clk);
         accepted = (ch == 1'b0) ? o_req_tready : o_cpl_tready;
      end while (!accepted);
   endtask

   // Valid stays high across back-to-back packets of one channel
   task automatic drive_channel(input pcie_tx_pkg::t_ch_id ch);
      in_beat_t beat;
      while (stage_q[ch].size() != 0) begin
         beat = stage_q[ch].pop_front();
         send_beat(ch, beat);
      end
      @(negedge avl_clk);
      set_channel(ch, 1'b0, '0);
   endtask

   // Builds a packet of random data with full keep except on the last beat
   task automatic plan_pkt(input pcie_tx_pkg::t_ch_id ch, input int nbeats,
                           input logic [KEEP_W-1:0] last_keep,
                           input pcie_tx_pkg::t_err_info err_info);
      in_beat_t  ib;
      out_beat_t ob;
      err_t      eb;
      for (int b = 0; b < nbeats; b++) begin
         ib.data  = {$urandom(), $urandom()};
         ib.last  = (b == nbeats - 1);
         ib.keep  = ib.last ? last_keep : '1;
         ob.data  = ib.data;
         ob.sop   = (b == 0);
         ob.eop   = ib.last;
         ob.empty = EMPTY_W'(KEEP_W - $countones(ib.keep));
         ob.chan  = ch;
         stage_q[ch].push_back(ib);
         exp_q.push_back(ob);
         if (ib.last && err_info != pcie_tx_pkg::ERR_NONE) begin
            eb.chan = ch;
            eb.info = err_info;
            err_q.push_back(eb);
         end
      end
   endtask

   task automatic wait_drained();
      while (exp_q.size() != 0) begin
         @(posedge avl_clk);
      end
      repeat (2) @(posedge avl_clk);
      expect_true(err_q.size() == 0, "expected error pulse never seen");
      err_q.delete();
   endtask

   // ------------------------------
   // Output monitor and watchdog
   // ------------------------------
   task automatic monitor_outputs();
      out_beat_t exp;
      out_beat_t held;
      err_t      eexp;
      logic      stalled;
      stalled = 1'b0;
      forever begin
         @(posedge avl_clk);
         if (!i_rst_n) begin
            stalled = 1'b0;
         end else begin
            // A stalled beat must stay put until accepted
            if (stalled) begin
               if (!o_avl_tx_valid) begin
                  note_error("o_avl_tx_valid dropped while the beat was stalled");
               end else begin
                  compare_beat(held, o_avl_tx_data, o_avl_tx_sop, o_avl_tx_eop,
                               o_avl_tx_empty, o_avl_tx_chan);
               end
            end
            if (o_avl_tx_valid && i_avl_tx_ready) begin
               if (exp_q.size() == 0) begin
                  note_error("output beat delivered when none was expected");
               end else begin
                  exp = exp_q.pop_front();
                  compare_beat(exp, o_avl_tx_data, o_avl_tx_sop, o_avl_tx_eop,
                               o_avl_tx_empty, o_avl_tx_chan);
               end
            end
            stalled    = o_avl_tx_valid && !i_avl_tx_ready;
            held.data  = o_avl_tx_data;
            held.sop   = o_avl_tx_sop;
            held.eop   = o_avl_tx_eop;
            held.empty = o_avl_tx_empty;
            held.chan  = o_avl_tx_chan;
            if (o_err_valid) begin
               if (!o_avl_tx_valid) begin
                  note_error("error pulse without an output beat");
               end
               if (err_q.size() == 0) begin
                  note_error("unexpected error pulse");
               end else begin
                  eexp = err_q.pop_front();
                  compare_err(eexp.chan, o_err_chan, eexp.info, o_err_info);
               end
            end
         end
      end
   endtask

   task automatic watch_cycles();
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge avl_clk);
         cycle_count++;
      end
      $display("timeout: run stopped after %0d cycles", cycle_count);
      $display("TEST FAILED");
      $finish;
   endtask

   // ------------------------------
   // Directed tests
   // ------------------------------
   task automatic reset_and_single_packet();
      @(posedge avl_clk);
      expect_true(!o_avl_tx_valid, "o_avl_tx_valid not low after reset");
      expect_true(!o_err_valid, "o_err_valid not low after reset");
      plan_pkt(1'b0, 3, 8'h0F, pcie_tx_pkg::ERR_NONE);
      drive_channel(1'b0);
      wait_drained();
   endtask

   // Fresh reset so channel 0 wins the first tie
   task automatic interleave_both_channels();
      apply_reset();
      plan_pkt(1'b0, 3, 8'hFF, pcie_tx_pkg::ERR_NONE);
      plan_pkt(1'b1, 2, 8'h3F, pcie_tx_pkg::ERR_NONE);
      plan_pkt(1'b0, 2, 8'h01, pcie_tx_pkg::ERR_NONE);
      plan_pkt(1'b1, 3, 8'h7F, pcie_tx_pkg::ERR_NONE);
      fork
         drive_channel(1'b0);
         drive_channel(1'b1);
      join
      wait_drained();
   endtask

   task automatic random_output_ready();
      logic                rand_done;
      pcie_tx_pkg::t_ch_id ch;
      rand_done = 1'b0;
      fork
         begin
            while (!rand_done) begin
               @(negedge avl_clk);
               i_avl_tx_ready = ($urandom() & 32'd1) != 0;
            end
         end
         begin
            for (int p = 0; p < 4; p++) begin
               ch = pcie_tx_pkg::t_ch_id'(p & 1);
               plan_pkt(ch, 4, 8'h1F, pcie_tx_pkg::ERR_NONE);
               drive_channel(ch);
            end
            wait_drained();
            rand_done = 1'b1;
         end
      join
      @(negedge avl_clk);
      i_avl_tx_ready = 1'b1;
   endtask

   task automatic fill_under_backpressure();
      int n_accepted;
      n_accepted = 0;
      @(negedge avl_clk);
      i_avl_tx_ready = 1'b0;
      plan_pkt(1'b0, 12, 8'h03, pcie_tx_pkg::ERR_NONE);
      fork
         drive_channel(1'b0);
         begin
            do begin
               @(posedge avl_clk);
               if (i_req_tvalid && o_req_tready) begin
                  n_accepted++;
               end
            end while (o_req_tready || !i_req_tvalid);
            expect_true(!o_cpl_tready, "o_cpl_tready high while the FIFO was full");
            // The FIFO entries and the adapter's output register take the first beats
            expect_true(n_accepted == FIFO_DEPTH + 1,
                        "wrong number of beats accepted before the input ready fell");
            repeat (5) begin
               @(posedge avl_clk);
               expect_true(!o_req_tready, "o_req_tready rose while the output was stalled");
            end
            @(negedge avl_clk);
            i_avl_tx_ready = 1'b1;
         end
      join
      wait_drained();
   endtask

   task automatic malformed_keep();
      plan_pkt(1'b1, 1, 8'h00, pcie_tx_pkg::ERR_KEEP_ZERO);
      plan_pkt(1'b0, 1, 8'h05, pcie_tx_pkg::ERR_KEEP_GAP);
      drive_channel(1'b1);
      drive_channel(1'b0);
      wait_drained();
   endtask

   initial begin
      int errs_before;
      void'($urandom(13715));
      i_rst_n        = 1'b0;
      i_req_tvalid   = 1'b0;
      i_req_tdata    = '0;
      i_req_tkeep    = '0;
      i_req_tlast    = 1'b0;
      i_cpl_tvalid   = 1'b0;
      i_cpl_tdata    = '0;
      i_cpl_tkeep    = '0;
      i_cpl_tlast    = 1'b0;
      i_avl_tx_ready = 1'b0;
      fork
         monitor_outputs();
         watch_cycles();
      join_none
      apply_reset();

      errs_before = err_count;
      reset_and_single_packet();
      report_test("reset_and_single_packet", errs_before);
      errs_before = err_count;
      interleave_both_channels();
      report_test("interleave_both_channels", errs_before);
      errs_before = err_count;
      random_output_ready();
      report_test("random_output_ready", errs_before);
      errs_before = err_count;
      fill_under_backpressure();
      report_test("fill_under_backpressure", errs_before);
      errs_before = err_count;
      malformed_keep();
      report_test("malformed_keep", errs_before);

      $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, err_count);
      if (err_count == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
design/pcie_tx_pkg.sv
design/pcie_tx_stream_if.sv
design/pcie_tx_arb_mux.sv
design/pcie_tx_fifo.sv
design/pcie_tx_avst_adapter.sv
design/pcie_tx_top.sv
verification/tb_clk_gen.sv
verification/tb_pcie_tx_top.sv

//--- Makefile
# Verilator build and run of the PCIe transmit path testbench

TOP := tb_pcie_tx_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/10ps -f filelist.f \
		--top-module $(TOP) --Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@grep -qx "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
